/* rtl/sce_pkg.sv */
/* sce control package
   mode, bypass and sub-block status types shared by the control hub */
`default_nettype none

package sce_pkg;

    // default sizes, the top level passes its own values down
    // sub-block order from index 0: trng, aes, pke, hash, alu
    localparam int SUBCNT_DEF = 5;
    // engine reset stretch in clocks
    localparam int EXTCNT_DEF = 16;

    // operating mode
    // code 11 is not named but decodes as secure
    typedef enum logic [1:0] {
        MODE_NON = 2'b00,
        MODE_XLS = 2'b01,
        MODE_SEC = 2'b10
    } scemode_t;

    // bypass byte from nvr or devmode
    // declared msb first, ahb_en sits at bit 0
    typedef struct packed {
        logic [2:0] spare;
        logic       alu_sec;
        logic       pke_lock;
        logic       mode_lock;
        logic       quit_reset;
        logic       ahb_en;
    } bypass_t;

    // per sub-block status
    // busy is a level, done and err are single-cycle pulses
    typedef struct packed {
        logic [1:0] err;
        logic       done;
        logic       busy;
    } sub_status_t;

    // devmode forces every bypass on
    localparam bypass_t BYPASS_ALL = '1;

    // secure decode, upper bit set covers 10 and 11
    function automatic logic mode_is_sec(input scemode_t mode);
        return mode[1];
    endfunction

endpackage

`default_nettype wire

/* rtl/sce_reset_gen.sv */
/* engine reset extender
   holds sce_resetn low for EXTCNT clocks after arst_n or a soft request */
`default_nettype none

module sce_reset_gen #(
    parameter int EXTCNT = sce_pkg::EXTCNT_DEF
)(
    input  logic clk,
    input  logic arst_n,
    input  logic soft_reset_req,
    output logic sce_resetn
);

    // counter width, at least one bit
    localparam int CW = (EXTCNT > 1) ? $clog2(EXTCNT) : 1;

    logic [CW-1:0] ext_cnt;
    logic          cnt_hit;
    logic          ext_done;

    // terminal count reached
    assign cnt_hit = (ext_cnt == CW'(EXTCNT - 1));

    // saturating stretch counter
    // soft request restarts it from zero on the sampling edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ext_cnt  <= '0;
            ext_done <= 1'b0;
        end else if (soft_reset_req) begin
            ext_cnt  <= '0;
            ext_done <= 1'b0;
        end else begin
            // stop counting once the hit is seen
            if (!cnt_hit) begin
                ext_cnt <= ext_cnt + 1'b1;
            end
            // registered hit, rises on the EXTCNT-th edge
            ext_done <= cnt_hit;
        end
    end

    // output straight from a flop, no decode glitches
    assign sce_resetn = ext_done;

endmodule

`default_nettype wire

/* rtl/sce_mode_ctrl.sv */
/* mode control with lock and bypass decode
   derives pke lock, alu secure and access-control enable from the mode */
`default_nettype none

module sce_mode_ctrl (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               devmode,
    input  sce_pkg::bypass_t   nvr_bypass,
    input  logic               mode_wr,
    input  sce_pkg::scemode_t  mode_wdat,
    input  logic               ar_reset,
    output logic               soft_reset_req,
    output logic               secmode,
    output logic               pke_ahb_lock,
    output logic               alu_sec,
    output logic               ac_enable
);

    sce_pkg::bypass_t  byp;
    sce_pkg::scemode_t mode_q;
    logic              mode_sec;
    logic              wr_sec;
    logic              wr_ok;
    logic              leave_sec;
    logic              quit_req;

    // effective bypass word
    // devmode pin overrides the nvr byte completely
    assign byp = devmode ? sce_pkg::BYPASS_ALL : nvr_bypass;

    // current and requested security level
    assign mode_sec = sce_pkg::mode_is_sec(mode_q);
    assign wr_sec   = sce_pkg::mode_is_sec(mode_wdat);

    // secure mode locks the register
    // mode_lock bypass reopens it
    assign wr_ok = mode_wr && (!mode_sec || byp.mode_lock);

    // accepted write that drops out of secure
    assign leave_sec = wr_ok && mode_sec && !wr_sec;

    // leaving secure wipes the engine unless quit_reset is bypassed
    assign quit_req = leave_sec && !byp.quit_reset;

    // mode register
    // only arst_n clears it, the soft reset leaves it alone
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode_q <= sce_pkg::MODE_NON;
        end else if (wr_ok) begin
            mode_q <= mode_wdat;
        end
    end

    // soft reset request, one-cycle registered pulse
    // set on the same edge that updates the mode
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            soft_reset_req <= 1'b0;
        end else begin
            soft_reset_req <= ar_reset || quit_req;
        end
    end

    // security controls follow the mode register
    assign secmode   = mode_sec;
    assign ac_enable = mode_sec;

    // pke bus lock, can be bypassed for debug
    assign pke_ahb_lock = mode_sec && !byp.pke_lock;

    // alu secure flag, same idea
    assign alu_sec = mode_sec && !byp.alu_sec;

endmodule

`default_nettype wire

/* rtl/sce_status_agg.sv */
/* sub-block status aggregation
   busy pass-through plus sticky done and error flags with masked clear */
`default_nettype none

module sce_status_agg #(
    parameter int SUBCNT = sce_pkg::SUBCNT_DEF
)(
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                sce_resetn,
    input  sce_pkg::sub_status_t [SUBCNT-1:0]   sub_status,
    input  logic [SUBCNT-1:0]                   clr_done,
    input  logic [SUBCNT-1:0]                   clr_err,
    output logic [SUBCNT-1:0]                   busy,
    output logic [SUBCNT-1:0]                   intr,
    output logic [SUBCNT-1:0]                   err
);

    logic [SUBCNT-1:0] done_vec;
    logic [SUBCNT-1:0] err_vec;
    logic [SUBCNT-1:0] intr_q;
    logic [SUBCNT-1:0] err_q;

    // sticky update, a new set beats a clear in the same cycle
    function automatic logic [SUBCNT-1:0] sticky_next(
        input logic [SUBCNT-1:0] q,
        input logic [SUBCNT-1:0] set,
        input logic [SUBCNT-1:0] clr
    );
        return (q & ~clr) | set;
    endfunction

    // unpack the per-block status words
    always_comb begin
        for (int i = 0; i < SUBCNT; i++) begin
            busy[i]     = sub_status[i].busy;
            done_vec[i] = sub_status[i].done;
            // both error codes fold into one flag
            err_vec[i]  = |sub_status[i].err;
        end
    end

    // flag registers
    // engine reset holds them clear synchronously
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            intr_q <= '0;
            err_q  <= '0;
        end else if (!sce_resetn) begin
            intr_q <= '0;
            err_q  <= '0;
        end else begin
            intr_q <= sticky_next(intr_q, done_vec, clr_done);
            err_q  <= sticky_next(err_q, err_vec, clr_err);
        end
    end

    // interrupt and error lines straight from the flags
    assign intr = intr_q;
    assign err  = err_q;

endmodule

`default_nettype wire

/* rtl/sce_ctrl_top.sv */
/* crypto engine control and status hub
   reset extension, mode control and status aggregation */
`default_nettype none

module sce_ctrl_top #(
    parameter int SUBCNT = sce_pkg::SUBCNT_DEF,
    parameter int EXTCNT = sce_pkg::EXTCNT_DEF
)(
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                devmode,
    input  sce_pkg::bypass_t                    nvr_bypass,
    input  logic                                mode_wr,
    input  sce_pkg::scemode_t                   mode_wdat,
    input  logic                                ar_reset,
    input  sce_pkg::sub_status_t [SUBCNT-1:0]   sub_status,
    input  logic [SUBCNT-1:0]                   clr_done,
    input  logic [SUBCNT-1:0]                   clr_err,
    output logic                                sce_resetn,
    output logic                                secmode,
    output logic                                pke_ahb_lock,
    output logic                                alu_sec,
    output logic                                ac_enable,
    output logic [SUBCNT-1:0]                   busy,
    output logic [SUBCNT-1:0]                   intr,
    output logic [SUBCNT-1:0]                   err
);

    // mode control to reset extender
    logic soft_reset_req;

    // engine reset stretch
    sce_reset_gen #(
        .EXTCNT (EXTCNT)
    ) rstgen (
        .clk            (clk),
        .arst_n         (arst_n),
        .soft_reset_req (soft_reset_req),
        .sce_resetn     (sce_resetn)
    );

    // mode, lock and bypass
    sce_mode_ctrl modectrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .devmode        (devmode),
        .nvr_bypass     (nvr_bypass),
        .mode_wr        (mode_wr),
        .mode_wdat      (mode_wdat),
        .ar_reset       (ar_reset),
        .soft_reset_req (soft_reset_req),
        .secmode        (secmode),
        .pke_ahb_lock   (pke_ahb_lock),
        .alu_sec        (alu_sec),
        .ac_enable      (ac_enable)
    );

    // status flags, cleared by the stretched reset
    sce_status_agg #(
        .SUBCNT (SUBCNT)
    ) stsagg (
        .clk        (clk),
        .arst_n     (arst_n),
        .sce_resetn (sce_resetn),
        .sub_status (sub_status),
        .clr_done   (clr_done),
        .clr_err    (clr_err),
        .busy       (busy),
        .intr       (intr),
        .err        (err)
    );

endmodule

`default_nettype wire

/* verification/sce_ctrl_asserts.sv */
/* concurrent checks for the control hub
   reset stretch, mode lock, bypass and sticky status flags */
`default_nettype none

module sce_ctrl_asserts #(
    parameter int SUBCNT = sce_pkg::SUBCNT_DEF,
    parameter int EXTCNT = sce_pkg::EXTCNT_DEF
)(
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                devmode,
    input  sce_pkg::bypass_t                    nvr_bypass,
    input  logic                                mode_wr,
    input  sce_pkg::scemode_t                   mode_wdat,
    input  logic                                ar_reset,
    input  sce_pkg::sub_status_t [SUBCNT-1:0]   sub_status,
    input  logic                                soft_reset_req,
    input  logic                                sce_resetn,
    input  logic                                secmode,
    input  logic                                pke_ahb_lock,
    input  logic                                alu_sec,
    input  logic                                ac_enable,
    input  logic [SUBCNT-1:0]                   busy,
    input  logic [SUBCNT-1:0]                   intr,
    input  logic [SUBCNT-1:0]                   err
);

    timeunit 1ns;
    timeprecision 1ps;

    // failed assertion count
    int unsigned fails = 0;

    sce_pkg::bypass_t  eff_byp;
    logic [1:0]        wdat_code;
    logic              wdat_sec;
    logic              wr_open;
    logic [SUBCNT-1:0] busy_exp;
    logic [SUBCNT-1:0] done_exp;
    logic [SUBCNT-1:0] err_exp;
    int unsigned       lo_run;

    // devmode turns on every bypass flag
    assign eff_byp   = devmode ? '1 : nvr_bypass;
    // codes 10 and 11 are secure
    assign wdat_code = mode_wdat;
    assign wdat_sec  = wdat_code[1];
    assign wr_open   = !secmode || eff_byp.mode_lock;

    always_comb begin
        for (int i = 0; i < SUBCNT; i++) begin
            busy_exp[i] = sub_status[i].busy;
            done_exp[i] = sub_status[i].done;
            err_exp[i]  = sub_status[i].err != 2'b00;
        end
    end

    // sampled low edges since the last release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lo_run <= 0;
        end else begin
            lo_run <= sce_resetn ? 0 : lo_run + 1;
        end
    end

    // engine reset low for exactly EXTCNT edges
    a_stretch: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(sce_resetn) |-> lo_run == EXTCNT)
        else begin
            $error("engine reset stretch length wrong");
            fails++;
        end

    a_soft_drop: assert property (@(posedge clk) disable iff (!arst_n)
        soft_reset_req |=> !sce_resetn)
        else begin
            $error("soft reset request did not drop the engine reset");
            fails++;
        end

    a_ar_req: assert property (@(posedge clk) disable iff (!arst_n)
        ar_reset |=> soft_reset_req)
        else begin
            $error("ar_reset gave no soft reset request");
            fails++;
        end

    // locked secure mode ignores writes
    a_lock_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (mode_wr && !wr_open) |=> secmode)
        else begin
            $error("write left a locked secure mode");
            fails++;
        end

    a_mode_write: assert property (@(posedge clk) disable iff (!arst_n)
        (mode_wr && wr_open) |=> secmode == $past(wdat_sec))
        else begin
            $error("accepted mode write not applied");
            fails++;
        end

    // leaving secure mode wipes the engine unless quit_reset is bypassed
    a_quit: assert property (@(posedge clk) disable iff (!arst_n)
        (mode_wr && secmode && eff_byp.mode_lock && !wdat_sec) |=>
        soft_reset_req == ($past(!eff_byp.quit_reset) || $past(ar_reset)))
        else begin
            $error("soft reset on leaving secure mode wrong");
            fails++;
        end

    a_derived: assert property (@(posedge clk) disable iff (!arst_n)
        (ac_enable == secmode) && (pke_ahb_lock == (secmode && !eff_byp.pke_lock))
        && (alu_sec == (secmode && !eff_byp.alu_sec)))
        else begin
            $error("mode derived controls wrong");
            fails++;
        end

    a_busy: assert property (@(posedge clk) disable iff (!arst_n)
        busy == busy_exp)
        else begin
            $error("busy does not follow the sub-blocks");
            fails++;
        end

    a_flags_clear: assert property (@(posedge clk) disable iff (!arst_n)
        !sce_resetn |=> (intr == '0) && (err == '0))
        else begin
            $error("flags not held clear in engine reset");
            fails++;
        end

    // pulses set their flag on the next edge
    a_flag_set: assert property (@(posedge clk) disable iff (!arst_n)
        sce_resetn |=> ((intr & $past(done_exp)) == $past(done_exp))
        && ((err & $past(err_exp)) == $past(err_exp)))
        else begin
            $error("status pulse did not set its flag");
            fails++;
        end

endmodule

bind sce_ctrl_top sce_ctrl_asserts #(
    .SUBCNT (SUBCNT),
    .EXTCNT (EXTCNT)
) chk (
    .clk            (clk),
    .arst_n         (arst_n),
    .devmode        (devmode),
    .nvr_bypass     (nvr_bypass),
    .mode_wr        (mode_wr),
    .mode_wdat      (mode_wdat),
    .ar_reset       (ar_reset),
    .sub_status     (sub_status),
    .soft_reset_req (soft_reset_req),
    .sce_resetn     (sce_resetn),
    .secmode        (secmode),
    .pke_ahb_lock   (pke_ahb_lock),
    .alu_sec        (alu_sec),
    .ac_enable      (ac_enable),
    .busy           (busy),
    .intr           (intr),
    .err            (err)
);

`default_nettype wire

/* verification/sce_ctrl_tb.sv */
/* testbench for the crypto engine control hub
   reset, mode, bypass and random status stimulus with assertion checks */
`default_nettype none

module sce_ctrl_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SUBCNT = sce_pkg::SUBCNT_DEF;
    localparam int EXTCNT = sce_pkg::EXTCNT_DEF;
    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 16;
    localparam int RANDOM_CYCLES = 300;
    // summed test lengths in clocks with margin
    localparam int RUN_CYCLES = RST_CYCLES + 4 * (EXTCNT + 12) + 40 + RANDOM_CYCLES;
    localparam int WATCHDOG_NS = (RUN_CYCLES + 200) * CLK_PERIOD;
    // directed clear masks
    localparam logic [SUBCNT-1:0] MASK_A = SUBCNT'(5'b00101);
    localparam logic [SUBCNT-1:0] MASK_B = SUBCNT'(5'b10010);

    logic                              clk;
    logic                              arst_n;
    logic                              devmode;
    sce_pkg::bypass_t                  nvr_bypass;
    logic                              mode_wr;
    sce_pkg::scemode_t                 mode_wdat;
    logic                              ar_reset;
    sce_pkg::sub_status_t [SUBCNT-1:0] sub_status;
    logic [SUBCNT-1:0]                 clr_done;
    logic [SUBCNT-1:0]                 clr_err;
    logic                              sce_resetn;
    logic                              secmode;
    logic                              pke_ahb_lock;
    logic                              alu_sec;
    logic                              ac_enable;
    logic [SUBCNT-1:0]                 busy;
    logic [SUBCNT-1:0]                 intr;
    logic [SUBCNT-1:0]                 err;

    int unsigned       fail_cnt;
    int unsigned       check_cnt;
    int unsigned       test_cnt;
    int unsigned       fails_at_start;
    int                edges;
    logic [31:0]       lcg_state;
    // expected sticky flags
    logic [SUBCNT-1:0] exp_intr;
    logic [SUBCNT-1:0] exp_err;
    logic [SUBCNT-1:0] rnd_busy;
    logic [SUBCNT-1:0] rnd_done;
    logic [2*SUBCNT-1:0] rnd_err;
    logic [SUBCNT-1:0] rnd_cd;
    logic [SUBCNT-1:0] rnd_ce;
    logic [31:0]       r;

    sce_ctrl_top #(
        .SUBCNT (SUBCNT),
        .EXTCNT (EXTCNT)
    ) uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .devmode      (devmode),
        .nvr_bypass   (nvr_bypass),
        .mode_wr      (mode_wr),
        .mode_wdat    (mode_wdat),
        .ar_reset     (ar_reset),
        .sub_status   (sub_status),
        .clr_done     (clr_done),
        .clr_err      (clr_err),
        .sce_resetn   (sce_resetn),
        .secmode      (secmode),
        .pke_ahb_lock (pke_ahb_lock),
        .alu_sec      (alu_sec),
        .ac_enable    (ac_enable),
        .busy         (busy),
        .intr         (intr),
        .err          (err)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // own value checks plus the bound assertion failures
    function automatic int unsigned total_fails();
        return fail_cnt + uut.chk.fails;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_cnt++;
        assert (got == exp) else begin
            $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
            fail_cnt++;
        end
    endtask

    task automatic finish_test(input string name);
        int unsigned n;
        n = total_fails() - fails_at_start;
        test_cnt++;
        if (n == 0) $display("test %0d %s: ok", test_cnt, name);
        else $display("test %0d %s: %0d failures", test_cnt, name, n);
        fails_at_start = total_fails();
    endtask

    // count edges until the engine reset releases
    task automatic wait_engine_reset(output int n_edges);
        int n;
        n = 0;
        while (!sce_resetn && n < EXTCNT + 8) begin
            @(negedge clk);
            n++;
        end
        if (!sce_resetn) begin
            $display("engine reset still active after %0d cycles", n);
            fail_cnt++;
        end
        n_edges = n;
    endtask

    task automatic write_mode(input sce_pkg::scemode_t m);
        mode_wdat = m;
        mode_wr   = 1'b1;
        @(negedge clk);
        mode_wr   = 1'b0;
    endtask

    // one status cycle and a compare against the sticky flag model
    task automatic apply_status(input logic [SUBCNT-1:0] busy_v, input logic [SUBCNT-1:0] done_v,
                                input logic [2*SUBCNT-1:0] err_codes,
                                input logic [SUBCNT-1:0] cd, input logic [SUBCNT-1:0] ce);
        logic [SUBCNT-1:0] err_v;
        for (int i = 0; i < SUBCNT; i++) begin
            sub_status[i].busy = busy_v[i];
            sub_status[i].done = done_v[i];
            sub_status[i].err  = err_codes[2*i +: 2];
            err_v[i] = err_codes[2*i +: 2] != 2'b00;
        end
        clr_done = cd;
        clr_err  = ce;
        @(negedge clk);
        // a pulse sets its flag even when the same bit is cleared
        for (int i = 0; i < SUBCNT; i++) begin
            exp_intr[i] = done_v[i] ? 1'b1 : (cd[i] ? 1'b0 : exp_intr[i]);
            exp_err[i]  = err_v[i] ? 1'b1 : (ce[i] ? 1'b0 : exp_err[i]);
        end
        compare_value("busy", busy, busy_v);
        compare_value("intr", intr, exp_intr);
        compare_value("err", err, exp_err);
    endtask

    // watchdog for a hung run
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        devmode = 1'b0;
        nvr_bypass = '0;
        mode_wr = 1'b0;
        mode_wdat = sce_pkg::MODE_NON;
        ar_reset = 1'b0;
        sub_status = '0;
        clr_done = '0;
        clr_err = '0;
        fail_cnt = 0;
        check_cnt = 0;
        test_cnt = 0;
        fails_at_start = 0;
        lcg_state = 32'h318aa049;
        exp_intr = '0;
        exp_err = '0;

        // test 1 stretch after the async reset
        repeat (RST_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        compare_value("sce_resetn", sce_resetn, 0);
        wait_engine_reset(edges);
        compare_value("reset stretch edges", edges, EXTCNT);
        compare_value("intr", intr, 0);
        compare_value("err", err, 0);
        compare_value("secmode", secmode, 0);
        compare_value("pke_ahb_lock", pke_ahb_lock, 0);
        compare_value("alu_sec", alu_sec, 0);
        compare_value("ac_enable", ac_enable, 0);
        compare_value("soft_reset_req", uut.soft_reset_req, 0);
        finish_test("reset stretch");

        // test 2 software reset wipes the flags
        apply_status('0, '1, {SUBCNT{2'b10}}, '0, '0);
        apply_status('0, '0, '0, '0, '0);
        ar_reset = 1'b1;
        @(negedge clk);
        ar_reset = 1'b0;
        compare_value("soft_reset_req", uut.soft_reset_req, 1);
        @(negedge clk);
        compare_value("sce_resetn", sce_resetn, 0);
        wait_engine_reset(edges);
        compare_value("soft reset stretch edges", edges, EXTCNT);
        compare_value("intr", intr, 0);
        compare_value("err", err, 0);
        exp_intr = '0;
        exp_err = '0;
        finish_test("software reset");

        // test 3 secure mode locks without bypass
        write_mode(sce_pkg::MODE_SEC);
        compare_value("secmode", secmode, 1);
        compare_value("ac_enable", ac_enable, 1);
        compare_value("pke_ahb_lock", pke_ahb_lock, 1);
        compare_value("alu_sec", alu_sec, 1);
        write_mode(sce_pkg::MODE_NON);
        compare_value("secmode", secmode, 1);
        compare_value("soft_reset_req", uut.soft_reset_req, 0);
        finish_test("mode lock");

        // test 4 devmode bypass and then nvr mode_lock alone
        devmode = 1'b1;
        @(negedge clk);
        compare_value("pke_ahb_lock", pke_ahb_lock, 0);
        compare_value("alu_sec", alu_sec, 0);
        compare_value("ac_enable", ac_enable, 1);
        write_mode(sce_pkg::MODE_NON);
        compare_value("secmode", secmode, 0);
        compare_value("soft_reset_req", uut.soft_reset_req, 0);
        @(negedge clk);
        compare_value("sce_resetn", sce_resetn, 1);
        devmode = 1'b0;
        nvr_bypass.mode_lock = 1'b1;
        write_mode(sce_pkg::MODE_SEC);
        compare_value("pke_ahb_lock", pke_ahb_lock, 1);
        write_mode(sce_pkg::MODE_XLS);
        compare_value("secmode", secmode, 0);
        compare_value("soft_reset_req", uut.soft_reset_req, 1);
        @(negedge clk);
        compare_value("sce_resetn", sce_resetn, 0);
        wait_engine_reset(edges);
        compare_value("quit reset stretch edges", edges, EXTCNT);
        nvr_bypass = '0;
        finish_test("bypass");

        // test 5 masked clear and set over clear before random pulses
        apply_status('0, '1, {SUBCNT{2'b01}}, '0, '0);
        apply_status('0, '0, '0, MASK_A, MASK_B);
        apply_status('1, MASK_A, '0, MASK_A, '0);
        apply_status('0, '0, (2*SUBCNT)'(4'b1100), '0, MASK_B);
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            for (int i = 0; i < SUBCNT; i++) begin
                r = lcg_next();
                rnd_busy[i] = r[16];
                rnd_done[i] = r[17] & r[18];
                // rare error codes
                rnd_err[2*i +: 2] = (r[19] & r[20] & r[21]) ? r[23:22] : 2'b00;
                rnd_cd[i] = r[24] & r[25];
                rnd_ce[i] = r[26] & r[27];
            end
            apply_status(rnd_busy, rnd_done, rnd_err, rnd_cd, rnd_ce);
        end
        apply_status('0, '0, '0, '0, '0);
        repeat (2) @(negedge clk);
        finish_test("sticky flags");

        $display("summary: %0d tests, %0d value checks, %0d failures",
                 test_cnt, check_cnt, total_fails());
        if (total_fails() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
rtl/sce_pkg.sv
rtl/sce_reset_gen.sv
rtl/sce_mode_ctrl.sv
rtl/sce_status_agg.sv
rtl/sce_ctrl_top.sv
verification/sce_ctrl_asserts.sv
verification/sce_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the control hub testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f verilog.f --top-module sce_ctrl_tb -o sim_sce_ctrl

out=$(./obj_dir/sim_sce_ctrl +verilator+error+limit+1000) || true
echo "$out"

# the run passes only if the pass line is present
echo "$out" | grep -qx "RESULT: PASS"
